// File: Makefile
# tool, flags, top module and file list
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing --assert
TOP = tb_spidergon_node
FILELIST = spidergon_node.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line also counts as failure
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/ejection_unit.sv
// ejection to the local CPU, one VC locked per packet and one flit per cycle
`timescale 1ns/1ns

module ejection_unit
(
	input logic clk,
	input logic reset,
	input logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_empty,
	input noc_flit_pkg::flit_t [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_head,
	output logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] deq,
	output noc_flit_pkg::flit_t cpu_out_flit,
	output logic cpu_out_valid
);

	// all VCs of all ports, port-major
	localparam int NQ = spidergon_pkg::NUM_PORTS * spidergon_pkg::NUM_VCS;
	localparam int QW = $clog2(NQ);

	logic locked;
	logic [QW-1:0] lock_idx;
	logic [NQ-1:0] req;
	logic [NQ-1:0] grant;
	logic [QW-1:0] grant_idx;
	logic [QW-1:0] sel_idx;
	logic do_deq;
	noc_flit_pkg::flit_t sel_flit;
	logic ends_packet;

	// new pick only between packets
	assign req = locked ? '0 : ~vc_empty;

	rr_arbiter #(.N(NQ)) u_arb (
		.clk(clk),
		.reset(reset),
		.req(req),
		.grant_en(!locked),
		.grant(grant)
	);

	always_comb
	begin
		grant_idx = '0;
		for (int q = 0; q < NQ; q++)
		begin
			if (grant[q])
				grant_idx = QW'(q);
		end
	end

	// locked VC stalls while empty
	// when unlocked the winner is dequeued at once
	assign sel_idx = locked ? lock_idx : grant_idx;
	assign do_deq = locked ? !vc_empty[lock_idx] : |grant;
	assign sel_flit = vc_head[sel_idx];
	assign ends_packet = (sel_flit.ftype == noc_flit_pkg::TAIL) ||
		(sel_flit.ftype == noc_flit_pkg::HEADER);

	always_comb
	begin
		deq = '0;
		deq[sel_idx] = do_deq;
	end

	// lock holds until a tail or header leaves the FIFO
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			locked <= 1'b0;
			lock_idx <= '0;
			cpu_out_valid <= 1'b0;
		end
		else
		begin
			cpu_out_valid <= do_deq;
			if (do_deq)
			begin
				locked <= !ends_packet;
				lock_idx <= sel_idx;
			end
		end
	end

	// delivered flit, valid the cycle after its dequeue
	always_ff @(posedge clk)
	begin
		if (do_deq)
			cpu_out_flit <= sel_flit;
	end

endmodule

// File: hw/injection_router.sv
// injection of CPU flits onto one output link by the Spidergon routing rule
`timescale 1ns/1ns

module injection_router
#(
	parameter int NODE_ID = 0
)
(
	input logic clk,
	input logic reset,
	input noc_flit_pkg::flit_t cpu_in_flit,
	input logic cpu_in_valid,
	output noc_flit_pkg::flit_t [spidergon_pkg::NUM_PORTS-1:0] out_flit,
	output logic [spidergon_pkg::NUM_PORTS-1:0] out_valid
);

	localparam int NN = spidergon_pkg::NUM_NODES;
	localparam int NW = spidergon_pkg::NODE_W;
	localparam int DW = spidergon_pkg::DIR_W;

	logic is_lead;
	logic [NW-1:0] rel;
	logic [DW-1:0] route;
	logic [DW-1:0] dir_q;
	logic [DW-1:0] cur_dir;

	assign is_lead = (cpu_in_flit.ftype == noc_flit_pkg::HEAD) ||
		(cpu_in_flit.ftype == noc_flit_pkg::HEADER);

	// clockwise hop count from this node to the destination
	assign rel = NW'((int'(cpu_in_flit.payload.head_fields.dest) + NN - NODE_ID) % NN);

	// near quarter clockwise, far quarter anticlockwise, middle across
	always_comb
	begin
		if (rel == '0)
			route = spidergon_pkg::STOP;
		else if (int'(rel) <= NN / 4)
			route = spidergon_pkg::CLOCKWISE;
		else if (int'(rel) >= NN - NN / 4)
			route = spidergon_pkg::ANTI;
		else
			route = spidergon_pkg::ACROSS;
	end

	// body and tail reuse the head's direction
	always_ff @(posedge clk)
	begin
		if (reset)
			dir_q <= spidergon_pkg::STOP;
		else if (cpu_in_valid && is_lead)
			dir_q <= route;
	end

	assign cur_dir = is_lead ? route : dir_q;

	// one register stage per link, idle links carry zeros
	// STOP matches no link, so the flit is dropped
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_flit <= '0;
			out_valid <= '0;
		end
		else
		begin
			for (int p = 0; p < spidergon_pkg::NUM_PORTS; p++)
			begin
				if (cpu_in_valid && cur_dir == DW'(p))
				begin
					out_flit[p] <= cpu_in_flit;
					out_valid[p] <= 1'b1;
				end
				else
				begin
					out_flit[p] <= '0;
					out_valid[p] <= 1'b0;
				end
			end
		end
	end

endmodule

// File: hw/input_port.sv
// input port of one link: VC selection, reservation update and per-VC FIFOs
`timescale 1ns/1ns

module input_port
#(
	parameter int FIFO_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input noc_flit_pkg::flit_t in_flit,
	input logic in_valid,
	input logic [spidergon_pkg::NUM_VCS-1:0] deq,
	output logic [spidergon_pkg::NUM_VCS-1:0] vc_ready,
	output logic [spidergon_pkg::NUM_VCS-1:0] vc_full,
	output logic [spidergon_pkg::NUM_VCS-1:0] vc_empty,
	output noc_flit_pkg::flit_t [spidergon_pkg::NUM_VCS-1:0] vc_head
);

	localparam int NV = spidergon_pkg::NUM_VCS;
	localparam int VW = spidergon_pkg::VC_W;

	vc_table_if vt ();

	logic is_lead;
	logic is_head;
	logic is_tail;
	logic [NV-1:0] arb_req;
	logic [NV-1:0] grant;
	logic [NV-1:0] cand;
	logic [NV-1:0] target;
	logic [VW-1:0] target_idx;
	logic hit;
	logic [NV-1:0] enq;
	logic accepted;

	// head and header both need a fresh VC
	// only head keeps it reserved until the tail
	assign is_lead = (in_flit.ftype == noc_flit_pkg::HEAD) ||
		(in_flit.ftype == noc_flit_pkg::HEADER);
	assign is_head = (in_flit.ftype == noc_flit_pkg::HEAD);
	assign is_tail = (in_flit.ftype == noc_flit_pkg::TAIL);

	// arbiter only sees free VCs, and only for a lead flit
	assign arb_req = (in_valid && is_lead) ? ~vt.busy : '0;

	rr_arbiter #(.N(NV)) u_arb (
		.clk(clk),
		.reset(reset),
		.req(arb_req),
		.grant_en(accepted && is_lead),
		.grant(grant)
	);

	// lead flits take the grant, the rest follow their owner
	assign cand = is_lead ? grant : vt.match;

	// lowest candidate wins, so at most one FIFO is written
	always_comb
	begin
		hit = 1'b0;
		target_idx = '0;
		for (int v = NV - 1; v >= 0; v--)
		begin
			if (cand[v])
			begin
				hit = 1'b1;
				target_idx = VW'(v);
			end
		end
		target = '0;
		target[target_idx] = hit;
	end

	// flit is lost if its VC is full or none qualifies
	assign enq = (in_valid ? target : '0) & ~vc_full;
	assign accepted = |enq;

	// reservation updates take effect at the next edge
	assign vt.alloc_en = accepted && is_head;
	assign vt.alloc_vc = target_idx;
	assign vt.release_en = accepted && is_tail;
	assign vt.release_vc = target_idx;
	assign vt.flit_prev_vc = in_flit.prev_vc;

	vc_table u_table (
		.clk(clk),
		.reset(reset),
		.tbl(vt.table_side)
	);

	// a free VC can take a new head
	assign vc_ready = ~vt.busy;

	for (genvar v = 0; v < NV; v++)
	begin : g_vc
		vc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
			.clk(clk),
			.reset(reset),
			.enq(enq[v]),
			.enq_flit(in_flit),
			.deq(deq[v]),
			.full(vc_full[v]),
			.empty(vc_empty[v]),
			.front_flit(vc_head[v])
		);
	end

endmodule

// File: hw/noc_flit_pkg.sv
// noc flit format: type codes, field widths and the two-way decoded flit word
package noc_flit_pkg;

	// flit type field sits in the top bits of the word
	localparam int TYPE_W = 2;

	// type codes
	// header is a single-flit packet, head opens a multi-flit one
	localparam logic [TYPE_W-1:0] HEAD = 2'b01;
	localparam logic [TYPE_W-1:0] HEADER = 2'b11;
	localparam logic [TYPE_W-1:0] BODY = 2'b10;
	localparam logic [TYPE_W-1:0] TAIL = 2'b00;

	// field widths
	localparam int PAYLOAD_W = 16;
	localparam int HEAD_DATA_W = 10;
	// dest and src share what is left of a head payload, 3 bits each
	localparam int ADDR_W = (PAYLOAD_W - HEAD_DATA_W) / 2;
	// type, one previous-VC bit, payload
	localparam int FLIT_W = TYPE_W + 1 + PAYLOAD_W;

	// head and header flits carry routing fields
	typedef struct packed {
		logic [ADDR_W-1:0] dest;
		logic [ADDR_W-1:0] src;
		logic [HEAD_DATA_W-1:0] data;
	} head_fields_t;

	// body and tail flits carry only data
	typedef struct packed {
		logic [PAYLOAD_W-1:0] data;
	} body_fields_t;

	// same 16 bits, read according to the flit type
	typedef union packed {
		head_fields_t head_fields;
		body_fields_t body_fields;
	} payload_t;

	typedef struct packed {
		logic [TYPE_W-1:0] ftype;
		logic prev_vc;
		payload_t payload;
	} flit_t;

endpackage

// File: hw/rr_arbiter.sv
// round-robin arbiter, one-hot grant with priority rotating past the last winner
`timescale 1ns/1ns

module rr_arbiter
#(
	parameter int N = 2
)
(
	input logic clk,
	input logic reset,
	input logic [N-1:0] req,
	input logic grant_en,
	output logic [N-1:0] grant
);

	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

	logic [IDX_W-1:0] last_idx;
	logic [IDX_W-1:0] grant_idx;

	// search starts just after the last winner and wraps
	always_comb
	begin
		int cand;
		grant = '0;
		grant_idx = last_idx;
		for (int i = 1; i <= N; i++)
		begin
			cand = (int'(last_idx) + i) % N;
			if (grant == '0 && req[cand])
			begin
				grant[cand] = 1'b1;
				grant_idx = IDX_W'(cand);
			end
		end
	end

	// reset value puts requester 0 first in line
	always_ff @(posedge clk)
	begin
		if (reset)
			last_idx <= IDX_W'(N - 1);
		else if (grant_en && |req)
			last_idx <= grant_idx;
	end

endmodule

// File: hw/spidergon_node.sv
// spidergon node top, three input ports feeding CPU ejection plus CPU injection
`timescale 1ns/1ns

module spidergon_node
#(
	parameter int NODE_ID = 0,
	parameter int FIFO_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input logic [noc_flit_pkg::FLIT_W-1:0] in_flit_across,
	input logic [noc_flit_pkg::FLIT_W-1:0] in_flit_clockwise,
	input logic [noc_flit_pkg::FLIT_W-1:0] in_flit_anticlockwise,
	// bit order follows the direction codes, anti 0, clockwise 1, across 2
	input logic [spidergon_pkg::NUM_PORTS-1:0] in_valid,
	input logic [noc_flit_pkg::FLIT_W-1:0] cpu_in_flit,
	input logic cpu_in_valid,
	// two bits per port, port p owns bits 2p and 2p+1
	output logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_ready,
	output logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_full,
	output logic [noc_flit_pkg::FLIT_W-1:0] out_flit_across,
	output logic [noc_flit_pkg::FLIT_W-1:0] out_flit_clockwise,
	output logic [noc_flit_pkg::FLIT_W-1:0] out_flit_anticlockwise,
	output logic [spidergon_pkg::NUM_PORTS-1:0] out_valid,
	output logic [noc_flit_pkg::FLIT_W-1:0] cpu_out_flit,
	output logic cpu_out_valid
);

	localparam int NP = spidergon_pkg::NUM_PORTS;
	localparam int NV = spidergon_pkg::NUM_VCS;

	// links indexed by direction code
	noc_flit_pkg::flit_t port_flit [NP];
	noc_flit_pkg::flit_t [NP-1:0] link_flit;
	noc_flit_pkg::flit_t [NP*NV-1:0] vc_head;
	logic [NP*NV-1:0] vc_empty;
	logic [NP*NV-1:0] deq;

	assign port_flit[spidergon_pkg::ACROSS] = in_flit_across;
	assign port_flit[spidergon_pkg::CLOCKWISE] = in_flit_clockwise;
	assign port_flit[spidergon_pkg::ANTI] = in_flit_anticlockwise;

	for (genvar p = 0; p < NP; p++)
	begin : g_port
		input_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_port (
			.clk(clk),
			.reset(reset),
			.in_flit(port_flit[p]),
			.in_valid(in_valid[p]),
			.deq(deq[p*NV +: NV]),
			.vc_ready(vc_ready[p*NV +: NV]),
			.vc_full(vc_full[p*NV +: NV]),
			.vc_empty(vc_empty[p*NV +: NV]),
			.vc_head(vc_head[p*NV +: NV])
		);
	end

	// every buffered flit goes to the CPU
	ejection_unit u_eject (
		.clk(clk),
		.reset(reset),
		.vc_empty(vc_empty),
		.vc_head(vc_head),
		.deq(deq),
		.cpu_out_flit(cpu_out_flit),
		.cpu_out_valid(cpu_out_valid)
	);

	injection_router #(.NODE_ID(NODE_ID)) u_inject (
		.clk(clk),
		.reset(reset),
		.cpu_in_flit(cpu_in_flit),
		.cpu_in_valid(cpu_in_valid),
		.out_flit(link_flit),
		.out_valid(out_valid)
	);

	assign out_flit_across = link_flit[spidergon_pkg::ACROSS];
	assign out_flit_clockwise = link_flit[spidergon_pkg::CLOCKWISE];
	assign out_flit_anticlockwise = link_flit[spidergon_pkg::ANTI];

endmodule

// File: hw/spidergon_pkg.sv
// spidergon topology constants: ring size, link ports, VCs and direction codes
package spidergon_pkg;

	// ring of nodes, each also linked to the node straight across
	localparam int NUM_NODES = 8;
	localparam int NODE_W = $clog2(NUM_NODES);

	// link ports per node, across, clockwise and anticlockwise
	localparam int NUM_PORTS = 3;

	// virtual channels per input port
	localparam int NUM_VCS = 2;
	localparam int VC_W = 1;

	// direction codes
	// also used as the port index for link arrays
	localparam int DIR_W = 2;
	localparam logic [DIR_W-1:0] ANTI = 2'd0;
	localparam logic [DIR_W-1:0] CLOCKWISE = 2'd1;
	localparam logic [DIR_W-1:0] ACROSS = 2'd2;
	// local delivery, no link used
	localparam logic [DIR_W-1:0] STOP = 2'd3;

endpackage

// File: hw/vc_fifo.sv
// flit FIFO of one virtual channel, circular buffer with full and empty flags
`timescale 1ns/1ns

module vc_fifo
#(
	parameter int FIFO_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input logic enq,
	input noc_flit_pkg::flit_t enq_flit,
	input logic deq,
	output logic full,
	output logic empty,
	output noc_flit_pkg::flit_t front_flit
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	noc_flit_pkg::flit_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_enq;
	logic do_deq;

	// wrap at the depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	// enqueue on full and dequeue on empty are dropped here
	assign do_enq = enq && !full;
	assign do_deq = deq && !empty;
	assign front_flit = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_enq)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_deq)
				rd_ptr <= next_ptr(rd_ptr);
			// count moves only when exactly one side acts
			if (do_enq && !do_deq)
				count <= count + 1'b1;
			else if (do_deq && !do_enq)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enq)
			mem[wr_ptr] <= enq_flit;
	end

endmodule

// File: hw/vc_table.sv
// per-port VC reservation table, busy flag and stored previous-VC for each VC
`timescale 1ns/1ns

module vc_table
(
	input logic clk,
	input logic reset,
	vc_table_if.table_side tbl
);

	localparam int NV = spidergon_pkg::NUM_VCS;
	localparam int VW = spidergon_pkg::VC_W;

	logic [NV-1:0] busy_q;
	// upstream VC that owns each reserved VC
	logic [VW-1:0] prev_q [NV];
	logic [NV-1:0] match_w;

	// reservation flags
	// allocation wins over release on the same VC
	always_ff @(posedge clk)
	begin
		if (reset)
			busy_q <= '0;
		else
		begin
			for (int v = 0; v < NV; v++)
			begin
				if (tbl.alloc_en && tbl.alloc_vc == VW'(v))
					busy_q[v] <= 1'b1;
				else if (tbl.release_en && tbl.release_vc == VW'(v))
					busy_q[v] <= 1'b0;
			end
		end
	end

	// owner recorded when a head reserves the VC
	always_ff @(posedge clk)
	begin
		if (tbl.alloc_en)
			prev_q[tbl.alloc_vc] <= tbl.flit_prev_vc;
	end

	// body and tail flits find their VC by owner
	always_comb
	begin
		for (int v = 0; v < NV; v++)
			match_w[v] = busy_q[v] && (prev_q[v] == tbl.flit_prev_vc);
	end

	assign tbl.busy = busy_q;
	assign tbl.match = match_w;

endmodule

// File: hw/vc_table_if.sv
// VC table link between an input port datapath and its reservation table
`timescale 1ns/1ns

interface vc_table_if;

	// head flit reserves a VC
	logic alloc_en;
	logic [spidergon_pkg::VC_W-1:0] alloc_vc;
	// tail flit frees its VC
	logic release_en;
	logic [spidergon_pkg::VC_W-1:0] release_vc;
	// previous-VC field of the flit on the link this cycle
	logic [spidergon_pkg::VC_W-1:0] flit_prev_vc;

	// reservation state, one bit per VC
	logic [spidergon_pkg::NUM_VCS-1:0] busy;
	// one-hot, busy VC whose stored previous-VC equals flit_prev_vc
	logic [spidergon_pkg::NUM_VCS-1:0] match;

	modport port_side (
		output alloc_en, alloc_vc, release_en, release_vc, flit_prev_vc,
		input busy, match
	);

	modport table_side (
		input alloc_en, alloc_vc, release_en, release_vc, flit_prev_vc,
		output busy, match
	);

endinterface

// File: spidergon_node.f
hw/noc_flit_pkg.sv
hw/spidergon_pkg.sv
hw/vc_table_if.sv
hw/vc_table.sv
hw/vc_fifo.sv
hw/rr_arbiter.sv
hw/input_port.sv
hw/ejection_unit.sv
hw/injection_router.sv
hw/spidergon_node.sv
test/spidergon_node_properties.sv
test/tb_spidergon_node.sv

// File: test/spidergon_node_properties.sv
// spidergon node checker: single ejection dequeue, idle links after reset, VC fill ownership
`timescale 1ns/1ns

module spidergon_node_properties
(
	input logic clk,
	input logic reset,
	input logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] deq,
	input logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_empty,
	input logic [spidergon_pkg::NUM_PORTS-1:0] out_valid,
	input logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_ready,
	input logic [spidergon_pkg::NUM_PORTS*spidergon_pkg::NUM_VCS-1:0] vc_full
);

	localparam int NQ = spidergon_pkg::NUM_PORTS * spidergon_pkg::NUM_VCS;

	// raised by any failing assertion below
	logic failed = 1'b0;

	// ejection pulls one flit at most, from one non-empty VC
	one_deq: assert property (@(posedge clk) disable iff (reset)
		$onehot0(deq) && (deq & vc_empty) == '0)
		else
		begin
			failed = 1'b1;
			$error("ejection dequeued more than one VC or an empty VC in one cycle");
		end

	// links come out of reset idle
	idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> out_valid == '0)
		else
		begin
			failed = 1'b1;
			$error("output link valid in the cycle after reset");
		end

	// only a body or tail of a reserved VC can fill it
	for (genvar v = 0; v < NQ; v++)
	begin : g_fill
		fill_when_reserved: assert property (@(posedge clk) disable iff (reset)
			$rose(vc_full[v]) |-> !$past(vc_ready[v]))
			else
			begin
				failed = 1'b1;
				$error("VC %0d became full while it was free", v);
			end
	end

endmodule

bind spidergon_node spidergon_node_properties props0 (
	.clk(clk),
	.reset(reset),
	.deq(deq),
	.vc_empty(vc_empty),
	.out_valid(out_valid),
	.vc_ready(vc_ready),
	.vc_full(vc_full)
);

// File: test/tb_spidergon_node.sv
// spidergon node testbench: table-driven injection and link traffic, scoreboard on CPU ejection
`timescale 1ns/1ns

module tb_spidergon_node;

	localparam int NODE_ID = 0;
	// deep enough to hold a whole 3-flit packet behind a locked one
	localparam int FIFO_DEPTH = 4;
	localparam int NP = spidergon_pkg::NUM_PORTS;
	localparam int NV = spidergon_pkg::NUM_VCS;
	localparam int NQ = NP * NV;
	localparam int TIMEOUT = 200;

	// row kinds
	localparam logic [2:0] INJ = 3'd0;
	localparam logic [2:0] LINK = 3'd1;
	localparam logic [2:0] IDLE = 3'd2;
	localparam logic [2:0] FREE = 3'd3;
	localparam logic [2:0] FULL = 3'd4;
	localparam logic [2:0] NOT_FULL = 3'd5;
	localparam logic [2:0] DRAIN = 3'd6;

	localparam logic [1:0] HEAD = noc_flit_pkg::HEAD;
	localparam logic [1:0] HEADER = noc_flit_pkg::HEADER;
	localparam logic [1:0] BODY = noc_flit_pkg::BODY;
	localparam logic [1:0] TAIL = noc_flit_pkg::TAIL;

	// link expected per destination as seen from node 0
	localparam logic [1:0] ROUTE_FROM_NODE [8] = '{
		spidergon_pkg::STOP, spidergon_pkg::CLOCKWISE, spidergon_pkg::CLOCKWISE,
		spidergon_pkg::ACROSS, spidergon_pkg::ACROSS, spidergon_pkg::ACROSS,
		spidergon_pkg::ANTI, spidergon_pkg::ANTI
	};

	// exp is the link for INJ, deliver flag for LINK, free VC count for FREE
	typedef struct packed {
		logic [2:0] kind;
		logic [1:0] port;
		logic [1:0] ftype;
		logic vc;
		logic [2:0] dest;
		logic [15:0] data;
		logic [1:0] exp;
	} row_t;

	logic clk;
	logic reset;
	noc_flit_pkg::flit_t link_in [NP];
	logic [NP-1:0] in_valid;
	noc_flit_pkg::flit_t cpu_in_flit;
	logic cpu_in_valid;
	logic [NQ-1:0] vc_ready;
	logic [NQ-1:0] vc_full;
	noc_flit_pkg::flit_t out_flit_across;
	noc_flit_pkg::flit_t out_flit_clockwise;
	noc_flit_pkg::flit_t out_flit_anticlockwise;
	logic [NP-1:0] out_valid;
	noc_flit_pkg::flit_t cpu_out_flit;
	logic cpu_out_valid;

	row_t rows [$];
	// one expected queue per packet slot indexed by port * NV + vc field
	noc_flit_pkg::flit_t exp_q [NQ][$];
	// slot of the packet being delivered or -1 between packets
	int cur_q;
	int seed;

	spidergon_node #(
		.NODE_ID(NODE_ID),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.in_flit_across(link_in[spidergon_pkg::ACROSS]),
		.in_flit_clockwise(link_in[spidergon_pkg::CLOCKWISE]),
		.in_flit_anticlockwise(link_in[spidergon_pkg::ANTI]),
		.in_valid(in_valid),
		.cpu_in_flit(cpu_in_flit),
		.cpu_in_valid(cpu_in_valid),
		.vc_ready(vc_ready),
		.vc_full(vc_full),
		.out_flit_across(out_flit_across),
		.out_flit_clockwise(out_flit_clockwise),
		.out_flit_anticlockwise(out_flit_anticlockwise),
		.out_valid(out_valid),
		.cpu_out_flit(cpu_out_flit),
		.cpu_out_valid(cpu_out_valid)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	// head and header carry dest and src, body and tail carry plain data
	function automatic noc_flit_pkg::flit_t make_flit(input logic [1:0] ftype, input logic vc,
		input logic [2:0] dest, input logic [15:0] data);
		noc_flit_pkg::flit_t f;
		f.ftype = ftype;
		f.prev_vc = vc;
		if (ftype == HEAD || ftype == HEADER)
		begin
			f.payload.head_fields.dest = dest;
			f.payload.head_fields.src = 3'(NODE_ID);
			f.payload.head_fields.data = data[9:0];
		end
		else
			f.payload.body_fields.data = data;
		return f;
	endfunction

	function automatic noc_flit_pkg::flit_t link_out(input int dir);
		if (dir == int'(spidergon_pkg::ANTI))
			return out_flit_anticlockwise;
		if (dir == int'(spidergon_pkg::CLOCKWISE))
			return out_flit_clockwise;
		return out_flit_across;
	endfunction

	function automatic int pending_flits();
		int n;
		n = 0;
		for (int q = 0; q < NQ; q++)
			n += exp_q[q].size();
		return n;
	endfunction

	function automatic void add_row(input logic [2:0] kind, input int port,
		input logic [1:0] ftype, input logic vc, input logic [2:0] dest,
		input logic [15:0] data, input logic [1:0] exp);
		rows.push_back('{kind, 2'(port), ftype, vc, dest, data, exp});
	endfunction

	// a packet must come out whole on the CPU side before the next one starts
	task automatic check_delivery(input noc_flit_pkg::flit_t got);
		int pick;
		logic lead;
		pick = cur_q;
		lead = (got.ftype == HEAD) || (got.ftype == HEADER);
		if (pick < 0)
		begin
			for (int q = 0; q < NQ; q++)
			begin
				if (pick < 0 && lead && exp_q[q].size() > 0 && exp_q[q][0] == got)
					pick = q;
			end
		end
		assert (pick >= 0 && exp_q[pick].size() > 0)
		else stop_with_error($sformatf("Unexpected flit %h delivered to the CPU at time %0t",
			got, $time));
		assert (exp_q[pick][0] == got)
		else stop_with_error($sformatf("Mismatch at time %0t: cpu_out_flit expected %h got %h",
			$time, exp_q[pick][0], got));
		void'(exp_q[pick].pop_front());
		cur_q = (got.ftype == TAIL || got.ftype == HEADER) ? -1 : pick;
	endtask

	always @(negedge clk)
	begin
		if (!reset && cpu_out_valid)
			check_delivery(cpu_out_flit);
	end

	// the bound checker raises its flag on any assertion failure
	always @(negedge clk)
	begin
		assert (!dut0.props0.failed)
		else stop_with_error($sformatf("A bound property of the DUT failed before time %0t",
			$time));
	end

	// one cycle later the flit sits on exactly the expected link while the others stay idle
	task automatic inject_and_check(input row_t r);
		noc_flit_pkg::flit_t f;
		noc_flit_pkg::flit_t want;
		logic [NP-1:0] exp_valid;
		f = make_flit(r.ftype, r.vc, r.dest, r.data);
		exp_valid = (r.exp == spidergon_pkg::STOP) ? '0 : NP'(1) << r.exp;
		cpu_in_flit = f;
		cpu_in_valid = 1'b1;
		@(negedge clk);
		cpu_in_valid = 1'b0;
		assert (out_valid == exp_valid)
		else stop_with_error($sformatf("Mismatch at time %0t: out_valid expected %b got %b",
			$time, exp_valid, out_valid));
		for (int p = 0; p < NP; p++)
		begin
			want = exp_valid[p] ? f : '0;
			assert (link_out(p) == want)
			else stop_with_error($sformatf("Mismatch at time %0t: out_flit[%0d] expected %h got %h",
				$time, p, want, link_out(p)));
		end
	endtask

	task automatic wait_full_level(input int port, input logic level);
		int n;
		n = 0;
		while ((|vc_full[port*NV +: NV]) != level && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		assert ((|vc_full[port*NV +: NV]) == level)
		else stop_with_error($sformatf("Timeout waiting for vc_full of port %0d to reach %0b",
			port, level));
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((pending_flits() != 0 || cur_q >= 0) && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		assert (pending_flits() == 0 && cur_q < 0)
		else stop_with_error("Timeout waiting for buffered flits to reach the CPU");
	endtask

	task automatic apply_row(input row_t r);
		noc_flit_pkg::flit_t f;
		@(negedge clk);
		in_valid = '0;
		cpu_in_valid = 1'b0;
		case (r.kind)
			INJ: inject_and_check(r);
			LINK:
			begin
				f = make_flit(r.ftype, r.vc, r.dest, r.data);
				link_in[r.port] = f;
				in_valid[r.port] = 1'b1;
				if (r.exp[0])
					exp_q[int'(r.port) * NV + int'(r.vc)].push_back(f);
			end
			FREE:
			begin
				assert ($countones(vc_ready[r.port*NV +: NV]) == int'(r.exp))
				else stop_with_error($sformatf(
					"Mismatch at time %0t: free VCs in vc_ready[%0d] expected %0d got %b",
					$time, r.port, r.exp, vc_ready[r.port*NV +: NV]));
			end
			FULL: wait_full_level(r.port, 1'b1);
			NOT_FULL: wait_full_level(r.port, 1'b0);
			DRAIN: wait_drain();
			default: ;
		endcase
	endtask

	task automatic build_table();
		int a;
		int b;
		int c;
		int q;
		int p;
		a = spidergon_pkg::ANTI;
		b = spidergon_pkg::CLOCKWISE;
		c = spidergon_pkg::ACROSS;
		// head, body and tail injected towards every destination
		for (int d = 0; d < spidergon_pkg::NUM_NODES; d++)
		begin
			add_row(INJ, 0, HEAD, 0, 3'(d), 16'($random(seed)), ROUTE_FROM_NODE[d]);
			add_row(INJ, 0, BODY, 0, 0, 16'($random(seed)), ROUTE_FROM_NODE[d]);
			add_row(INJ, 0, TAIL, 0, 0, 16'($random(seed)), ROUTE_FROM_NODE[d]);
		end
		add_row(INJ, 0, HEADER, 0, 3'd4, 16'($random(seed)), spidergon_pkg::ACROSS);
		// one anticlockwise VC stays held from head to tail
		add_row(LINK, a, HEAD, 0, 3'(NODE_ID), 16'h0155, 1);
		add_row(FREE, a, 0, 0, 0, 0, 1);
		add_row(LINK, a, BODY, 0, 0, 16'hbeef, 1);
		add_row(LINK, a, BODY, 0, 0, 16'h1234, 1);
		add_row(LINK, a, TAIL, 0, 0, 16'h9abc, 1);
		add_row(FREE, a, 0, 0, 0, 0, 2);
		add_row(DRAIN, 0, 0, 0, 0, 0, 0);
		// two packets interleaved on across and clockwise
		for (int i = 0; i < 3; i++)
		begin
			add_row(LINK, c, (i == 0) ? HEAD : (i == 1) ? BODY : TAIL, 0,
				3'($random(seed)), 16'($random(seed)), 1);
			add_row(LINK, b, (i == 0) ? HEAD : (i == 1) ? BODY : TAIL, 1,
				3'($random(seed)), 16'($random(seed)), 1);
		end
		add_row(DRAIN, 0, 0, 0, 0, 0, 0);
		// open packet on across keeps ejection locked
		q = c;
		p = b;
		add_row(LINK, q, HEAD, 1, 3'd2, 16'h0aaa, 1);
		add_row(IDLE, 0, 0, 0, 0, 0, 0);
		add_row(IDLE, 0, 0, 0, 0, 0, 0);
		// both clockwise VCs taken so a third head is lost
		add_row(LINK, p, HEAD, 0, 3'd5, 16'h0111, 1);
		add_row(LINK, p, HEAD, 1, 3'd6, 16'h0222, 1);
		add_row(FREE, p, 0, 0, 0, 0, 0);
		add_row(LINK, p, HEAD, 0, 3'd7, 16'h0333, 0);
		for (int i = 1; i < FIFO_DEPTH; i++)
			add_row(LINK, p, BODY, 0, 0, 16'($random(seed)), 1);
		add_row(FULL, p, 0, 0, 0, 0, 0);
		// release the held packet, then close the clockwise ones
		add_row(LINK, q, TAIL, 1, 0, 16'h5555, 1);
		add_row(LINK, p, TAIL, 1, 0, 16'h6666, 1);
		add_row(NOT_FULL, p, 0, 0, 0, 0, 0);
		add_row(LINK, p, TAIL, 0, 0, 16'h7777, 1);
		add_row(DRAIN, 0, 0, 0, 0, 0, 0);
	endtask

	initial
	begin
		seed = 66148;
		cur_q = -1;
		reset = 1'b1;
		in_valid = '0;
		cpu_in_valid = 1'b0;
		cpu_in_flit = '0;
		for (int p = 0; p < NP; p++)
			link_in[p] = '0;
		build_table();
		repeat (3) @(negedge clk);
		reset = 1'b0;
		// state straight after reset
		assert (vc_ready == '1)
		else stop_with_error($sformatf("Mismatch at time %0t: vc_ready expected %b got %b",
			$time, {NQ{1'b1}}, vc_ready));
		assert (vc_full == '0)
		else stop_with_error($sformatf("Mismatch at time %0t: vc_full expected 0 got %b",
			$time, vc_full));
		assert (out_valid == '0)
		else stop_with_error($sformatf("Mismatch at time %0t: out_valid expected 0 got %b",
			$time, out_valid));
		assert (cpu_out_valid == 1'b0)
		else stop_with_error($sformatf("Mismatch at time %0t: cpu_out_valid expected 0 got %b",
			$time, cpu_out_valid));
		foreach (rows[i])
			apply_row(rows[i]);
		// quiet cycles catch any late or extra delivery
		repeat (4) @(negedge clk);
		if (dut0.props0.failed)
			stop_with_error("A bound property of the DUT failed");
		else
		begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule
